//--- dtu_cdc.f
dtu_cdc_pkg.sv
dtu_cdc_lvl_sync.sv
dtu_cdc_handoff.sv
dtu_dm_port.sv
dtu_core_port.sv
dtu_havereset_fsm.sv
dtu_cdc.sv
tb_clkgen.sv
tb_dtu_cdc.sv

//--- dtu_cdc.sv
// top level of the debug module to core bridge, instances and wires
module dtu_cdc import dtu_cdc_pkg::*; (
  input  logic        dtu_cdc_clk,
  input  logic        cpurst_b,
  input  logic        sys_apb_clk,
  input  logic        sys_apb_rst_b,
  // debug bus side
  input  dm_lvl_t     dm_lvl,
  input  dm_evt_t     dm_evt,
  input  logic        itr_vld,
  input  debug_inst_t itr,
  input  logic        dm_wr_vld,
  input  dm_wr_cmd_t  dm_wr_cmd,
  output core_lvl_t   core_lvl,
  output logic        itr_done,
  output logic        debug_expt,
  output logic        wr_ready,
  output xlen_data_t  rx_data,
  // core side
  input  core_csr_t   core_csr,
  input  logic        dbgon,
  input  logic        retire_vld,
  input  logic        retire_debug_expt_vld,
  output logic        sync_halt_req,
  output logic        halt_on_reset,
  output logic        async_halt_req,
  output logic        async_halt_wakeup,
  output logic        resume_req,
  output logic        debug_inst_vld,
  output debug_inst_t debug_inst,
  output logic        core_wr_vld,
  output dm_wr_cmd_t  core_wr_cmd
);

  // ==================================================
  // crossing wires
  // ==================================================
  logic        dm_evt_vld;
  dm_lvl_t     dm_lvl_q;
  dm_lvl_t     dm_lvl_sync;
  logic        evt_dst_vld;
  dm_evt_t     evt_dst;
  logic        inst_dst_vld;
  debug_inst_t inst_dst;
  logic        wr_dst_vld;
  dm_wr_cmd_t  wr_dst;
  logic        core_evt_src_vld;
  core_evt_t   core_evt_src;
  logic        core_evt_dst_vld;
  core_evt_t   core_evt_dst;
  logic        rsp_src_vld;
  xlen_data_t  rsp_src;
  logic        rsp_dst_vld;
  xlen_data_t  rsp_dst;
  logic        ack_havereset;
  logic        halted;
  logic        havereset;
  core_lvl_t   core_lvl_src;

  assign core_lvl_src.halted    = halted;
  assign core_lvl_src.havereset = havereset;

  // ==================================================
  // debug bus side
  // ==================================================
  dtu_dm_port u_dm_port (
    .sys_apb_clk   (sys_apb_clk),
    .sys_apb_rst_b (sys_apb_rst_b),
    .dm_lvl        (dm_lvl),
    .dm_evt        (dm_evt),
    .itr_vld       (itr_vld),
    .itr           (itr),
    .dm_wr_vld     (dm_wr_vld),
    .dm_wr_cmd     (dm_wr_cmd),
    .core_evt_vld  (core_evt_dst_vld),
    .core_evt      (core_evt_dst),
    .rsp_vld       (rsp_dst_vld),
    .rsp_data      (rsp_dst),
    .core_lvl_sync (core_lvl_src),
    .evt_vld       (dm_evt_vld),
    .lvl_out       (dm_lvl_q),
    .core_lvl      (core_lvl),
    .itr_done      (itr_done),
    .debug_expt    (debug_expt),
    .wr_ready      (wr_ready),
    .rx_data       (rx_data)
  );

  // ==================================================
  // debug bus to core
  // ==================================================
  dtu_cdc_lvl_sync #(.lvl_t(dm_lvl_t)) u_dm_lvl_sync (
    .clk   (dtu_cdc_clk),
    .rst_b (cpurst_b),
    .src   (dm_lvl_q),
    .dst   (dm_lvl_sync)
  );

  dtu_cdc_handoff #(.payload_t(dm_evt_t)) u_evt_handoff (
    .src_clk   (sys_apb_clk),
    .src_rst_b (sys_apb_rst_b),
    .dst_clk   (dtu_cdc_clk),
    .dst_rst_b (cpurst_b),
    .src_vld   (dm_evt_vld),
    .src_data  (dm_evt),
    .dst_vld   (evt_dst_vld),
    .dst_data  (evt_dst)
  );

  dtu_cdc_handoff #(.payload_t(debug_inst_t)) u_inst_handoff (
    .src_clk   (sys_apb_clk),
    .src_rst_b (sys_apb_rst_b),
    .dst_clk   (dtu_cdc_clk),
    .dst_rst_b (cpurst_b),
    .src_vld   (itr_vld),
    .src_data  (itr),
    .dst_vld   (inst_dst_vld),
    .dst_data  (inst_dst)
  );

  dtu_cdc_handoff #(.payload_t(dm_wr_cmd_t)) u_wr_handoff (
    .src_clk   (sys_apb_clk),
    .src_rst_b (sys_apb_rst_b),
    .dst_clk   (dtu_cdc_clk),
    .dst_rst_b (cpurst_b),
    .src_vld   (dm_wr_vld),
    .src_data  (dm_wr_cmd),
    .dst_vld   (wr_dst_vld),
    .dst_data  (wr_dst)
  );

  // ==================================================
  // core to debug bus
  // ==================================================
  dtu_cdc_handoff #(.payload_t(core_evt_t)) u_core_evt_handoff (
    .src_clk   (dtu_cdc_clk),
    .src_rst_b (cpurst_b),
    .dst_clk   (sys_apb_clk),
    .dst_rst_b (sys_apb_rst_b),
    .src_vld   (core_evt_src_vld),
    .src_data  (core_evt_src),
    .dst_vld   (core_evt_dst_vld),
    .dst_data  (core_evt_dst)
  );

  dtu_cdc_handoff #(.payload_t(xlen_data_t)) u_rsp_handoff (
    .src_clk   (dtu_cdc_clk),
    .src_rst_b (cpurst_b),
    .dst_clk   (sys_apb_clk),
    .dst_rst_b (sys_apb_rst_b),
    .src_vld   (rsp_src_vld),
    .src_data  (rsp_src),
    .dst_vld   (rsp_dst_vld),
    .dst_data  (rsp_dst)
  );

  // ==================================================
  // core side
  // ==================================================
  dtu_core_port u_core_port (
    .dtu_cdc_clk           (dtu_cdc_clk),
    .cpurst_b              (cpurst_b),
    .dm_lvl_sync           (dm_lvl_sync),
    .evt_vld               (evt_dst_vld),
    .evt                   (evt_dst),
    .inst_vld              (inst_dst_vld),
    .inst                  (inst_dst),
    .wr_vld                (wr_dst_vld),
    .wr_cmd                (wr_dst),
    .core_csr              (core_csr),
    .dbgon                 (dbgon),
    .retire_vld            (retire_vld),
    .retire_debug_expt_vld (retire_debug_expt_vld),
    .sync_halt_req         (sync_halt_req),
    .halt_on_reset         (halt_on_reset),
    .async_halt_req        (async_halt_req),
    .async_halt_wakeup     (async_halt_wakeup),
    .resume_req            (resume_req),
    .ack_havereset         (ack_havereset),
    .debug_inst_vld        (debug_inst_vld),
    .debug_inst            (debug_inst),
    .core_wr_vld           (core_wr_vld),
    .core_wr_cmd           (core_wr_cmd),
    .rsp_vld               (rsp_src_vld),
    .rsp_data              (rsp_src),
    .core_evt_vld          (core_evt_src_vld),
    .core_evt              (core_evt_src),
    .halted                (halted)
  );

  dtu_havereset_fsm u_havereset_fsm (
    .dtu_cdc_clk   (dtu_cdc_clk),
    .cpurst_b      (cpurst_b),
    .ack_havereset (ack_havereset),
    .havereset     (havereset)
  );

endmodule

//--- dtu_cdc_handoff.sv
// toggle-based crossing of a one-cycle strobe with a typed payload held stable
module dtu_cdc_handoff #(
  parameter type payload_t = logic
) (
  input  logic     src_clk,
  input  logic     src_rst_b,
  input  logic     dst_clk,
  input  logic     dst_rst_b,
  input  logic     src_vld,
  input  payload_t src_data,
  output logic     dst_vld,
  output payload_t dst_data
);

  // ==================================================
  // source domain
  // ==================================================
  logic     src_tgl;
  payload_t hold_q;

  // one flip per request
  always_ff @(posedge src_clk or negedge src_rst_b)
  begin
    if (!src_rst_b)
      src_tgl <= 1'b0;
    else if (src_vld)
      src_tgl <= ~src_tgl;
  end

  // payload stays put until the next request
  always_ff @(posedge src_clk)
  begin
    if (src_vld)
      hold_q <= src_data;
  end

  // ==================================================
  // destination domain
  // ==================================================
  // toggle through three flops, [0] is the metastable one
  logic [2:0] tgl_sync;
  logic       tgl_edge;

  always_ff @(posedge dst_clk or negedge dst_rst_b)
  begin
    if (!dst_rst_b)
      tgl_sync <= 3'b000;
    else
      tgl_sync <= {tgl_sync[1:0], src_tgl};
  end

  // any change between the last two stages
  assign tgl_edge = tgl_sync[2] ^ tgl_sync[1];

  always_ff @(posedge dst_clk or negedge dst_rst_b)
  begin
    if (!dst_rst_b)
      dst_vld <= 1'b0;
    else
      dst_vld <= tgl_edge;
  end

  // hold_q has been stable for at least two dst edges here
  always_ff @(posedge dst_clk)
  begin
    if (tgl_edge)
      dst_data <= hold_q;
  end

  // requests closer than the crossing time merge or vanish
  a_dst_vld_single : assert property (
    @(posedge dst_clk) disable iff (!dst_rst_b)
    dst_vld |=> !dst_vld
  );

endmodule

//--- dtu_cdc_lvl_sync.sv
// two-flop synchronizer for a typed bundle of levels
module dtu_cdc_lvl_sync #(
  parameter type lvl_t = logic
) (
  input  logic clk,
  input  logic rst_b,
  input  lvl_t src,
  output lvl_t dst
);

  // first stage may go metastable
  lvl_t meta_q;
  // second stage, settled copy
  lvl_t sync_q;

  always_ff @(posedge clk or negedge rst_b)
  begin
    if (!rst_b)
    begin
      meta_q <= '0;
      sync_q <= '0;
    end
    else
    begin
      meta_q <= src;
      sync_q <= meta_q;
    end
  end

  // levels follow after two destination edges
  assign dst = sync_q;

endmodule

//--- dtu_cdc_pkg.sv
// shared widths, payload structs, enums and level bundles for the debug cdc bridge
package dtu_cdc_pkg;

  // ==================================================
  // widths
  // ==================================================
  // core data width
  localparam int xlen      = 64;
  // physical address width of the pc
  localparam int pa_width  = 40;
  // debug instruction width
  localparam int itr_width = 32;

  // ==================================================
  // basic payload types
  // ==================================================
  typedef logic [xlen-1:0]      xlen_data_t;
  typedef logic [pa_width-1:0]  pa_t;
  typedef logic [itr_width-1:0] debug_inst_t;

  // read-back source of the register mailbox
  typedef enum logic [1:0] {
    sel_dscratch0 = 2'b00,
    sel_zero      = 2'b01,
    sel_pc        = 2'b10,
    sel_satp      = 2'b11
  } rd_sel_e;

  // write command, flag on top of the data word
  typedef struct packed {
    rd_sel_e    flg;
    xlen_data_t wdata;
  } dm_wr_cmd_t;

  // ==================================================
  // event and level bundles
  // ==================================================
  // debug bus to core, one-cycle events
  typedef struct packed {
    logic resume;
    logic ack_havereset;
  } dm_evt_t;

  // core to debug bus, one-cycle events
  typedef struct packed {
    logic itr_done;
    logic debug_expt;
  } core_evt_t;

  // debug bus to core, levels
  typedef struct packed {
    logic halt_req;
    logic async_halt_req;
    logic halt_on_reset;
  } dm_lvl_t;

  // core to debug bus, levels
  typedef struct packed {
    logic halted;
    logic havereset;
  } core_lvl_t;

  // csr values read back by the mailbox
  typedef struct packed {
    xlen_data_t dscratch0;
    xlen_data_t satp;
    pa_t        latest_pc;
  } core_csr_t;

  // post-reset have-reset sequence
  typedef enum logic [1:0] {
    st_idle       = 2'b00,
    st_pulse      = 2'b01,
    st_have_reset = 2'b10,
    st_pending    = 2'b11
  } havereset_state_e;

endpackage

//--- dtu_core_port.sv
// core side consumer, halt pulses, debug instruction, mailbox read mux and event launch
module dtu_core_port import dtu_cdc_pkg::*; (
  input  logic        dtu_cdc_clk,
  input  logic        cpurst_b,
  input  dm_lvl_t     dm_lvl_sync,
  input  logic        evt_vld,
  input  dm_evt_t     evt,
  input  logic        inst_vld,
  input  debug_inst_t inst,
  input  logic        wr_vld,
  input  dm_wr_cmd_t  wr_cmd,
  input  core_csr_t   core_csr,
  input  logic        dbgon,
  input  logic        retire_vld,
  input  logic        retire_debug_expt_vld,
  output logic        sync_halt_req,
  output logic        halt_on_reset,
  output logic        async_halt_req,
  output logic        async_halt_wakeup,
  output logic        resume_req,
  output logic        ack_havereset,
  output logic        debug_inst_vld,
  output debug_inst_t debug_inst,
  output logic        core_wr_vld,
  output dm_wr_cmd_t  core_wr_cmd,
  output logic        rsp_vld,
  output xlen_data_t  rsp_data,
  output logic        core_evt_vld,
  output core_evt_t   core_evt,
  output logic        halted
);

  // ==================================================
  // halt levels and async halt edges
  // ==================================================
  assign sync_halt_req = dm_lvl_sync.halt_req;
  assign halt_on_reset = dm_lvl_sync.halt_on_reset;

  logic async_q;
  logic async_qq;

  always_ff @(posedge dtu_cdc_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      async_q  <= 1'b0;
      async_qq <= 1'b0;
    end
    else
    begin
      async_q  <= dm_lvl_sync.async_halt_req;
      async_qq <= async_q;
    end
  end

  // wakeup straight off the rising edge
  assign async_halt_wakeup = dm_lvl_sync.async_halt_req & ~async_q;
  // halt request one cycle later
  assign async_halt_req    = async_q & ~async_qq;

  // events pass straight through
  assign resume_req    = evt_vld & evt.resume;
  assign ack_havereset = evt_vld & evt.ack_havereset;

  // ==================================================
  // debug instruction and mailbox write
  // ==================================================
  always_ff @(posedge dtu_cdc_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      debug_inst_vld <= 1'b0;
      debug_inst     <= '0;
    end
    else
    begin
      debug_inst_vld <= inst_vld;
      if (inst_vld)
        debug_inst <= inst;
    end
  end

  always_ff @(posedge dtu_cdc_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      core_wr_vld <= 1'b0;
    else
      core_wr_vld <= wr_vld;
  end

  // command held for the read mux
  always_ff @(posedge dtu_cdc_clk)
  begin
    if (wr_vld)
      core_wr_cmd <= wr_cmd;
  end

  // ==================================================
  // read-back mux
  // ==================================================
  xlen_data_t rd_mux;

  always_comb
  begin
    unique case (core_wr_cmd.flg)
      sel_dscratch0: rd_mux = core_csr.dscratch0;
      sel_zero:      rd_mux = '0;
      // pc zero-extended to xlen
      sel_pc:        rd_mux = {{(xlen-pa_width){1'b0}}, core_csr.latest_pc};
      sel_satp:      rd_mux = core_csr.satp;
    endcase
  end

  // response one cycle after the write strobe
  always_ff @(posedge dtu_cdc_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      rsp_vld <= 1'b0;
    else
      rsp_vld <= core_wr_vld;
  end

  always_ff @(posedge dtu_cdc_clk)
  begin
    if (core_wr_vld)
      rsp_data <= rd_mux;
  end

  // ==================================================
  // events and status back to the debug bus
  // ==================================================
  // itr retire only counts in debug mode
  assign core_evt.itr_done   = retire_vld & dbgon;
  assign core_evt.debug_expt = retire_debug_expt_vld;
  assign core_evt_vld        = core_evt.itr_done | core_evt.debug_expt;

  always_ff @(posedge dtu_cdc_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      halted <= 1'b0;
    else
      halted <= dbgon;
  end

  // one write per crossing, never stretched
  a_core_wr_single : assert property (
    @(posedge dtu_cdc_clk) disable iff (!cpurst_b)
    core_wr_vld |=> !core_wr_vld
  );

endmodule

//--- dtu_dm_port.sv
// debug-bus side producer, request launch, level capture and response registers
module dtu_dm_port import dtu_cdc_pkg::*; (
  input  logic        sys_apb_clk,
  input  logic        sys_apb_rst_b,
  input  dm_lvl_t     dm_lvl,
  input  dm_evt_t     dm_evt,
  input  logic        itr_vld,
  input  debug_inst_t itr,
  input  logic        dm_wr_vld,
  input  dm_wr_cmd_t  dm_wr_cmd,
  input  logic        core_evt_vld,
  input  core_evt_t   core_evt,
  input  logic        rsp_vld,
  input  xlen_data_t  rsp_data,
  input  core_lvl_t   core_lvl_sync,
  output logic        evt_vld,
  output dm_lvl_t     lvl_out,
  output core_lvl_t   core_lvl,
  output logic        itr_done,
  output logic        debug_expt,
  output logic        wr_ready,
  output xlen_data_t  rx_data
);

  // ==================================================
  // requests towards the core
  // ==================================================
  // any event bit starts a crossing
  assign evt_vld = |dm_evt;

  // launch flop so no glitch reaches the synchronizer
  always_ff @(posedge sys_apb_clk or negedge sys_apb_rst_b)
  begin
    if (!sys_apb_rst_b)
      lvl_out <= '0;
    else
      lvl_out <= dm_lvl;
  end

  // mailbox write in flight until its response comes back
  logic wr_pend;

  always_ff @(posedge sys_apb_clk or negedge sys_apb_rst_b)
  begin
    if (!sys_apb_rst_b)
      wr_pend <= 1'b0;
    else if (dm_wr_vld)
      wr_pend <= 1'b1;
    else if (rsp_vld)
      wr_pend <= 1'b0;
  end

  // ==================================================
  // responses from the core
  // ==================================================
  dtu_cdc_lvl_sync #(
    .lvl_t (core_lvl_t)
  ) u_core_lvl_sync (
    .clk   (sys_apb_clk),
    .rst_b (sys_apb_rst_b),
    .src   (core_lvl_sync),
    .dst   (core_lvl)
  );

  // split the event bundle
  assign itr_done   = core_evt_vld & core_evt.itr_done;
  assign debug_expt = core_evt_vld & core_evt.debug_expt;

  // ready one cycle behind the crossing, data on the same edge
  always_ff @(posedge sys_apb_clk or negedge sys_apb_rst_b)
  begin
    if (!sys_apb_rst_b)
    begin
      wr_ready <= 1'b0;
      rx_data  <= '0;
    end
    else
    begin
      wr_ready <= rsp_vld;
      if (rsp_vld)
        rx_data <= rsp_data;
    end
  end

  // a second write before the read-back returns would be dropped
  a_wr_no_overlap : assert property (
    @(posedge sys_apb_clk) disable iff (!sys_apb_rst_b)
    dm_wr_vld |-> !wr_pend && !$isunknown(dm_wr_cmd)
  );

  // instruction must be driven with its strobe
  a_itr_known : assert property (
    @(posedge sys_apb_clk) disable iff (!sys_apb_rst_b)
    itr_vld |-> !$isunknown(itr)
  );

endmodule

//--- dtu_havereset_fsm.sv
// have-reset state machine run once after core reset
module dtu_havereset_fsm import dtu_cdc_pkg::*; (
  input  logic dtu_cdc_clk,
  input  logic cpurst_b,
  input  logic ack_havereset,
  output logic havereset
);

  havereset_state_e state;
  havereset_state_e next_state;

  always_ff @(posedge dtu_cdc_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= st_idle;
    else
      state <= next_state;
  end

  // idle -> pulse -> have_reset, then wait for the debugger
  always_comb
  begin
    next_state = state;
    unique case (state)
      st_idle:       next_state = st_pulse;
      st_pulse:      next_state = st_have_reset;
      st_have_reset:
      begin
        if (ack_havereset)
          next_state = st_pending;
      end
      // terminal until the next core reset
      st_pending:    next_state = st_pending;
    endcase
  end

  // level for the debug bus, one flop behind the state
  always_ff @(posedge dtu_cdc_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      havereset <= 1'b0;
    else
      havereset <= (state == st_have_reset);
  end

  // only cpurst_b restarts the sequence
  a_pending_sticky : assert property (
    @(posedge dtu_cdc_clk) disable iff (!cpurst_b)
    (state == st_pending) |=> (state == st_pending)
  );

endmodule

//--- tb_clkgen.sv
// testbench clocks for both domains and their power-on resets
module tb_clkgen (
  output logic dtu_cdc_clk,
  output logic cpurst_b,
  output logic sys_apb_clk,
  output logic sys_apb_rst_b
);

  // half periods, core 40 and debug bus 100
  localparam int core_half = 20;
  localparam int apb_half  = 50;
  localparam int rst_cycles = 10;

  initial
  begin
    dtu_cdc_clk = 1'b0;
    forever #core_half dtu_cdc_clk = ~dtu_cdc_clk;
  end

  initial
  begin
    sys_apb_clk = 1'b0;
    forever #apb_half sys_apb_clk = ~sys_apb_clk;
  end

  // each reset held for ten cycles of its own clock
  initial
  begin
    cpurst_b = 1'b0;
    repeat (rst_cycles) @(posedge dtu_cdc_clk);
    #5 cpurst_b = 1'b1;
  end

  initial
  begin
    sys_apb_rst_b = 1'b0;
    repeat (rst_cycles) @(posedge sys_apb_clk);
    #5 sys_apb_rst_b = 1'b1;
  end

endmodule

//--- tb_dtu_cdc.sv
// testbench top with directed tests, compare tasks, pulse counters, lfsr and watchdog
module tb_dtu_cdc import dtu_cdc_pkg::*; ();

  localparam int num_tests   = 5;
  localparam int core_period = 40;
  // pulse window in destination cycles
  localparam int win         = 20;

  logic        dtu_cdc_clk;
  logic        cpurst_b;
  logic        sys_apb_clk;
  logic        sys_apb_rst_b;
  dm_lvl_t     dm_lvl;
  dm_evt_t     dm_evt;
  logic        itr_vld;
  debug_inst_t itr;
  logic        dm_wr_vld;
  dm_wr_cmd_t  dm_wr_cmd;
  core_lvl_t   core_lvl;
  logic        itr_done;
  logic        debug_expt;
  logic        wr_ready;
  xlen_data_t  rx_data;
  core_csr_t   core_csr;
  logic        dbgon;
  logic        retire_vld;
  logic        retire_debug_expt_vld;
  logic        sync_halt_req;
  logic        halt_on_reset;
  logic        async_halt_req;
  logic        async_halt_wakeup;
  logic        resume_req;
  logic        debug_inst_vld;
  debug_inst_t debug_inst;
  logic        core_wr_vld;
  dm_wr_cmd_t  core_wr_cmd;

  tb_clkgen u_clkgen (
    .dtu_cdc_clk   (dtu_cdc_clk),
    .cpurst_b      (cpurst_b),
    .sys_apb_clk   (sys_apb_clk),
    .sys_apb_rst_b (sys_apb_rst_b)
  );

  dtu_cdc u_dtu_cdc (
    .dtu_cdc_clk           (dtu_cdc_clk),
    .cpurst_b              (cpurst_b),
    .sys_apb_clk           (sys_apb_clk),
    .sys_apb_rst_b         (sys_apb_rst_b),
    .dm_lvl                (dm_lvl),
    .dm_evt                (dm_evt),
    .itr_vld               (itr_vld),
    .itr                   (itr),
    .dm_wr_vld             (dm_wr_vld),
    .dm_wr_cmd             (dm_wr_cmd),
    .core_lvl              (core_lvl),
    .itr_done              (itr_done),
    .debug_expt            (debug_expt),
    .wr_ready              (wr_ready),
    .rx_data               (rx_data),
    .core_csr              (core_csr),
    .dbgon                 (dbgon),
    .retire_vld            (retire_vld),
    .retire_debug_expt_vld (retire_debug_expt_vld),
    .sync_halt_req         (sync_halt_req),
    .halt_on_reset         (halt_on_reset),
    .async_halt_req        (async_halt_req),
    .async_halt_wakeup     (async_halt_wakeup),
    .resume_req            (resume_req),
    .debug_inst_vld        (debug_inst_vld),
    .debug_inst            (debug_inst),
    .core_wr_vld           (core_wr_vld),
    .core_wr_cmd           (core_wr_cmd)
  );

  // ==================================================
  // pulse counters sampled mid-cycle
  // ==================================================
  int core_cyc    = 0;
  int cnt_wakeup  = 0;
  int cnt_async   = 0;
  int cnt_resume  = 0;
  int cnt_inst    = 0;
  int cnt_core_wr = 0;
  int wakeup_cyc  = 0;
  int async_cyc   = 0;
  int cnt_itr_done   = 0;
  int cnt_debug_expt = 0;
  int cnt_wr_ready   = 0;
  logic [31:0] lfsr_state = 32'h2bc2;

  always @(posedge dtu_cdc_clk)
    core_cyc <= core_cyc + 1;

  always @(negedge dtu_cdc_clk)
  begin
    if (async_halt_wakeup === 1'b1)
    begin
      cnt_wakeup = cnt_wakeup + 1;
      wakeup_cyc = core_cyc;
    end
    if (async_halt_req === 1'b1)
    begin
      cnt_async = cnt_async + 1;
      async_cyc = core_cyc;
    end
    if (resume_req === 1'b1)
      cnt_resume = cnt_resume + 1;
    if (debug_inst_vld === 1'b1)
      cnt_inst = cnt_inst + 1;
    if (core_wr_vld === 1'b1)
      cnt_core_wr = cnt_core_wr + 1;
  end

  always @(negedge sys_apb_clk)
  begin
    if (itr_done === 1'b1)
      cnt_itr_done = cnt_itr_done + 1;
    if (debug_expt === 1'b1)
      cnt_debug_expt = cnt_debug_expt + 1;
    if (wr_ready === 1'b1)
      cnt_wr_ready = cnt_wr_ready + 1;
  end

  // ==================================================
  // helpers
  // ==================================================
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "stopped at first error");
  endtask

  // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic lsb;
    lsb = s[0];
    s = s >> 1;
    if (lsb)
      s = s ^ 32'h8020_0003;
    return s;
  endfunction

  // first bit drawn ends up on top
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[62:0], lfsr_state[0]};
    end
    return val;
  endfunction

  task automatic wait_apb_cycles(input int n);
    repeat (n)
    begin
      @(posedge sys_apb_clk);
      #5;
    end
  endtask

  task automatic wait_core_cycles(input int n);
    repeat (n)
    begin
      @(posedge dtu_cdc_clk);
      #5;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp)
      fail_run($sformatf("Error: %s expected %h got %h", name, exp, got));
  endtask

  task automatic check_count(input string name, input int exp, input int got);
    if (got != exp)
      fail_run($sformatf("Error: %s expected %h got %h", name, exp, got));
  endtask

  task automatic check_data(input string name, input xlen_data_t exp, input xlen_data_t got);
    if (got !== exp)
      fail_run($sformatf("Error: %s expected %h got %h", name, exp, got));
  endtask

  task automatic check_inst(input string name, input debug_inst_t exp,
                            input debug_inst_t got);
    if (got !== exp)
      fail_run($sformatf("Error: %s expected %h got %h", name, exp, got));
  endtask

  task automatic check_wr_cmd(input string name, input dm_wr_cmd_t exp,
                              input dm_wr_cmd_t got);
    if (got !== exp)
      fail_run($sformatf("Error: %s expected %h got %h", name, exp, got));
  endtask

  // read-back source picked by the flag
  function automatic xlen_data_t expected_read(input rd_sel_e flg, input core_csr_t csr);
    case (flg)
      sel_dscratch0: return csr.dscratch0;
      // unsigned cast fills the top bits with zero
      sel_pc:        return xlen_data_t'(csr.latest_pc);
      sel_satp:      return csr.satp;
      default:       return '0;
    endcase
  endfunction

  // one-cycle event on the debug bus
  task automatic send_dm_evt(input logic resume, input logic ack);
    wait_apb_cycles(1);
    dm_evt.resume        = resume;
    dm_evt.ack_havereset = ack;
    wait_apb_cycles(1);
    dm_evt = '0;
  endtask

  // ==================================================
  // directed tests
  // ==================================================
  task automatic test_havereset();
    int n;
    // outputs quiet right after reset
    check_data("rx_data", '0, rx_data);
    check_inst("debug_inst", '0, debug_inst);
    check_bit("wr_ready", 1'b0, wr_ready);
    check_bit("debug_inst_vld", 1'b0, debug_inst_vld);
    n = 0;
    while (core_lvl.havereset !== 1'b1 && n < 40)
    begin
      wait_apb_cycles(1);
      n++;
    end
    check_bit("core_lvl.havereset", 1'b1, core_lvl.havereset);
    send_dm_evt(1'b0, 1'b1);
    n = 0;
    while (core_lvl.havereset !== 1'b0 && n < win)
    begin
      wait_apb_cycles(1);
      n++;
    end
    check_bit("core_lvl.havereset", 1'b0, core_lvl.havereset);
    // second ack finds the fsm parked
    send_dm_evt(1'b0, 1'b1);
    wait_apb_cycles(win);
    check_bit("core_lvl.havereset", 1'b0, core_lvl.havereset);
  endtask

  task automatic test_halt_levels();
    int base_wake;
    int base_async;
    wait_apb_cycles(1);
    dm_lvl.halt_req      = 1'b1;
    dm_lvl.halt_on_reset = 1'b1;
    wait_core_cycles(win);
    check_bit("sync_halt_req", 1'b1, sync_halt_req);
    check_bit("halt_on_reset", 1'b1, halt_on_reset);
    wait_apb_cycles(1);
    dm_lvl = '0;
    wait_core_cycles(win);
    check_bit("sync_halt_req", 1'b0, sync_halt_req);
    check_bit("halt_on_reset", 1'b0, halt_on_reset);
    // async level rise gives wakeup then halt pulse
    base_wake  = cnt_wakeup;
    base_async = cnt_async;
    wait_apb_cycles(1);
    dm_lvl.async_halt_req = 1'b1;
    wait_core_cycles(win);
    check_count("async_halt_wakeup pulses", 1, cnt_wakeup - base_wake);
    check_count("async_halt_req pulses", 1, cnt_async - base_async);
    check_count("async_halt_req cycle", wakeup_cyc + 1, async_cyc);
    // no more pulses while the level is held
    wait_core_cycles(win);
    check_count("async_halt_wakeup pulses", 1, cnt_wakeup - base_wake);
    check_count("async_halt_req pulses", 1, cnt_async - base_async);
    wait_apb_cycles(1);
    dm_lvl = '0;
    wait_core_cycles(win);
  endtask

  task automatic test_events();
    int base_resume;
    int base_expt;
    base_resume = cnt_resume;
    send_dm_evt(1'b1, 1'b0);
    wait_core_cycles(win);
    check_count("resume_req pulses", 1, cnt_resume - base_resume);
    base_expt = cnt_debug_expt;
    wait_core_cycles(1);
    retire_debug_expt_vld = 1'b1;
    wait_core_cycles(1);
    retire_debug_expt_vld = 1'b0;
    wait_apb_cycles(win);
    check_count("debug_expt pulses", 1, cnt_debug_expt - base_expt);
  endtask

  task automatic test_debug_inst();
    debug_inst_t val;
    int base_inst;
    int base_done;
    val = debug_inst_t'(take_bits(itr_width));
    base_inst = cnt_inst;
    wait_apb_cycles(1);
    itr     = val;
    itr_vld = 1'b1;
    wait_apb_cycles(1);
    itr_vld = 1'b0;
    wait_core_cycles(win);
    check_count("debug_inst_vld pulses", 1, cnt_inst - base_inst);
    check_inst("debug_inst", val, debug_inst);
    // retire in debug mode
    base_done = cnt_itr_done;
    wait_core_cycles(1);
    dbgon      = 1'b1;
    retire_vld = 1'b1;
    wait_core_cycles(1);
    retire_vld = 1'b0;
    wait_apb_cycles(win);
    check_count("itr_done pulses", 1, cnt_itr_done - base_done);
    check_bit("core_lvl.halted", 1'b1, core_lvl.halted);
    // out of debug mode the retire is ignored
    base_done = cnt_itr_done;
    wait_core_cycles(1);
    dbgon = 1'b0;
    wait_core_cycles(2);
    retire_vld = 1'b1;
    wait_core_cycles(1);
    retire_vld = 1'b0;
    wait_apb_cycles(win);
    check_count("itr_done pulses", 0, cnt_itr_done - base_done);
    check_bit("core_lvl.halted", 1'b0, core_lvl.halted);
  endtask

  task automatic test_mailbox();
    dm_wr_cmd_t cmd;
    int base_wr;
    int base_ready;
    int n;
    for (int i = 0; i < 4; i++)
    begin
      wait_core_cycles(1);
      core_csr.dscratch0 = take_bits(xlen);
      core_csr.satp      = take_bits(xlen);
      core_csr.latest_pc = pa_t'(take_bits(pa_width));
      cmd.flg   = rd_sel_e'(i);
      cmd.wdata = take_bits(xlen);
      base_wr    = cnt_core_wr;
      base_ready = cnt_wr_ready;
      wait_apb_cycles(1);
      dm_wr_cmd = cmd;
      dm_wr_vld = 1'b1;
      wait_apb_cycles(1);
      dm_wr_vld = 1'b0;
      // round trip ends with wr_ready
      n = 0;
      while (cnt_wr_ready == base_ready && n < win)
      begin
        wait_apb_cycles(1);
        n++;
      end
      if (cnt_wr_ready == base_ready)
        fail_run("wr_ready never came back after a mailbox write");
      wait_apb_cycles(win - n);
      check_count("core_wr_vld pulses", 1, cnt_core_wr - base_wr);
      check_wr_cmd("core_wr_cmd", cmd, core_wr_cmd);
      check_count("wr_ready pulses", 1, cnt_wr_ready - base_ready);
      check_data("rx_data", expected_read(cmd.flg, core_csr), rx_data);
    end
  endtask

  // ==================================================
  // main sequence and watchdog
  // ==================================================
  initial
  begin
    dm_lvl                = '0;
    dm_evt                = '0;
    itr_vld               = 1'b0;
    itr                   = '0;
    dm_wr_vld             = 1'b0;
    dm_wr_cmd             = '0;
    core_csr              = '0;
    dbgon                 = 1'b0;
    retire_vld            = 1'b0;
    retire_debug_expt_vld = 1'b0;
    wait (cpurst_b === 1'b1 && sys_apb_rst_b === 1'b1);
    wait_apb_cycles(1);
    test_havereset();
    test_halt_levels();
    test_events();
    test_debug_inst();
    test_mailbox();
    $display("Everything OK");
    $finish;
  end

  // time budget grows with the number of tests
  initial
  begin
    #(num_tests * 400 * core_period);
    fail_run("watchdog expired before the tests finished");
  end

endmodule
